// File: rtl/sram_pkg.sv
package sram_pkg;

  // one chip is 256K x 8, the word is striped across chips a byte per lane
  localparam int sram_addr_width = 18;
  localparam int sram_lane_width = 8;

  typedef logic [sram_addr_width-1:0] sram_addr_t;  // word address, shared by every lane
  typedef logic [sram_lane_width-1:0] lane_data_t;  // the byte that one chip holds

endpackage

// File: rtl/mem_test_pkg.sv
package mem_test_pkg;

  // one write sweep and one read sweep make a pass, the request states are the
  // idle cycle that keeps the strobe low between two accesses
  typedef enum logic [2:0] {
    idle,
    write_req,
    write_wait,
    read_req,
    read_wait,
    pass_end
  } seq_state_t;

  // the pattern word is addr * pattern_addr_mul + pass * pattern_pass_mul
  localparam logic [31:0] pattern_addr_mul = 32'h9e3779b9;
  localparam logic [31:0] pattern_pass_mul = 32'h7f4a7c15;  // shifts the pattern every pass

endpackage

// File: rtl/sram_lane_if.sv
interface sram_lane_if import sram_pkg::*; ();

  logic       req;    // one cycle pulse per access
  logic       we;
  sram_addr_t addr;
  lane_data_t wdata;
  lane_data_t rdata;  // valid together with ack
  logic       ack;    // one cycle pulse when the chip cycle is over

  modport split (
    output req,
    output we,
    output addr,
    output wdata
  );

  modport lane (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output rdata,
    output ack
  );

  // join is a reserved word, so the collecting side is named joiner
  modport joiner (
    input rdata,
    input ack
  );

endinterface

// File: rtl/mem_test_seq.sv
module mem_test_seq import sram_pkg::*, mem_test_pkg::*; #(
  parameter int NUM_S      = 4,
  parameter int NUM_BURSTS = 16,
  parameter int NUM_BEATS  = 8
) (
  input  logic                             clk,
  input  logic                             rst_n,
  output logic                             wb_cyc,
  output logic                             wb_stb,
  output logic                             wb_we,
  output sram_addr_t                       wb_adr,
  output logic [NUM_S*sram_lane_width-1:0] wb_dat_w,
  input  logic                             wb_ack,
  input  logic [NUM_S*sram_lane_width-1:0] wb_dat_r,
  output logic                             test_done,
  output logic                             test_pass
);

  localparam int word_width = NUM_S * sram_lane_width;
  localparam sram_addr_t last_addr = sram_addr_t'(NUM_BURSTS * NUM_BEATS - 1);

  seq_state_t  state;
  seq_state_t  state_nxt;
  sram_addr_t  addr_q;
  logic [31:0] pass_cnt;
  logic        pass_q;
  logic        last_hit;
  logic        access_done;

  // the testbench rebuilds the same word with its own reference function
  function automatic logic [word_width-1:0] pattern_word(sram_addr_t a, logic [31:0] k);
    logic [31:0] mix;
    mix = 32'(a) * pattern_addr_mul + k * pattern_pass_mul;
    return word_width'(mix);
  endfunction

  assign last_hit    = (addr_q == last_addr);
  assign access_done = wb_ack && (state == write_wait || state == read_wait);

  // the bus is decoded from the state, so address and data stay put until ack
  assign wb_stb    = (state == write_wait) || (state == read_wait);
  assign wb_cyc    = wb_stb;
  assign wb_we     = (state == write_wait);
  assign wb_adr    = addr_q;
  assign wb_dat_w  = pattern_word(addr_q, pass_cnt);  // also the expected word on reads
  assign test_done = (state == pass_end);
  assign test_pass = pass_q;

  always_comb begin
    state_nxt = state;
    case (state)
      idle:       state_nxt = write_req;
      write_req:  state_nxt = write_wait;  // strobe low for a cycle after every ack
      write_wait: begin
        if (wb_ack) begin
          state_nxt = last_hit ? read_req : write_req;
        end
      end
      read_req:   state_nxt = read_wait;
      read_wait:  begin
        if (wb_ack) begin
          state_nxt = last_hit ? pass_end : read_req;
        end
      end
      pass_end:   state_nxt = write_req;
      default:    state_nxt = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= idle;
      addr_q   <= '0;
      pass_cnt <= '0;
      pass_q   <= 1'b1;
    end else begin
      state <= state_nxt;

      // wraps to zero after the last write so the read sweep starts at the bottom
      if (access_done) begin
        addr_q <= last_hit ? '0 : addr_q + sram_addr_t'(1);
      end

      if (wb_ack && state == read_wait && wb_dat_r != wb_dat_w) begin
        pass_q <= 1'b0;  // sticky until the next reset
      end

      if (state == pass_end) begin
        pass_cnt <= pass_cnt + 32'd1;
      end
    end
  end

endmodule

// File: rtl/stripe_split.sv
module stripe_split import sram_pkg::*; #(
  parameter int NUM_S = 4
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             wb_cyc,
  input  logic                             wb_stb,
  input  logic                             wb_we,
  input  sram_addr_t                       wb_adr,
  input  logic [NUM_S*sram_lane_width-1:0] wb_dat_w,
  sram_lane_if.split                       lanes [NUM_S]
);

  logic issued;  // set once this strobe has been passed on to the lanes
  logic req;

  // the first strobe cycle fires at once, the lanes register everything themselves
  assign req = wb_cyc && wb_stb && !issued;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      issued <= 1'b0;
    end else if (!wb_stb) begin
      issued <= 1'b0;  // re-arm for the next access
    end else if (req) begin
      issued <= 1'b1;
    end
  end

  for (genvar i = 0; i < NUM_S; i++) begin : gen_lane
    assign lanes[i].req   = req;
    assign lanes[i].we    = wb_we;
    assign lanes[i].addr  = wb_adr;  // every chip sees the word address
    assign lanes[i].wdata = wb_dat_w[i*sram_lane_width +: sram_lane_width];
  end

endmodule

// File: rtl/sram_lane.sv
module sram_lane import sram_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  sram_lane_if.lane  bus,
  output sram_addr_t sram_addr,
  output lane_data_t sram_dout,
  output logic       sram_doe,
  input  lane_data_t sram_din,
  output logic       sram_we_n,
  output logic       sram_oe_n,
  output logic       sram_ce_n
);

  // phase 0 is idle, 1 selects the chip, 2 strobes, 3 releases the strobe
  logic [1:0] phase;
  logic       we_q;
  logic       start;

  assign start = (phase == 2'd0) && bus.req;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase     <= 2'd0;
      we_q      <= 1'b0;
      sram_ce_n <= 1'b1;
      sram_we_n <= 1'b1;
      sram_oe_n <= 1'b1;
      sram_doe  <= 1'b0;
      bus.ack   <= 1'b0;
    end else begin
      bus.ack <= 1'b0;
      case (phase)
        2'd0: begin
          if (bus.req) begin
            phase     <= 2'd1;
            we_q      <= bus.we;
            sram_ce_n <= 1'b0;
            sram_doe  <= bus.we;  // drive the pins a cycle before we_n falls
          end
        end
        2'd1: begin
          phase     <= 2'd2;
          sram_we_n <= !we_q;
          sram_oe_n <= we_q;
        end
        2'd2: begin
          phase     <= 2'd3;
          sram_we_n <= 1'b1;  // the chip latches write data on this rising edge
          sram_oe_n <= 1'b1;
          bus.ack   <= 1'b1;
        end
        default: begin
          // ce_n and the data drive are held through phase 3 for write hold time
          phase     <= 2'd0;
          sram_ce_n <= 1'b1;
          sram_doe  <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      sram_addr <= bus.addr;
      sram_dout <= bus.wdata;
    end

    // oe_n has been low for the whole cycle, so the data has settled
    if (phase == 2'd2 && !we_q) begin
      bus.rdata <= sram_din;
    end
  end

endmodule

// File: rtl/stripe_join.sv
module stripe_join import sram_pkg::*; #(
  parameter int NUM_S = 4
) (
  input  logic                             clk,
  input  logic                             rst_n,
  sram_lane_if.joiner                      lanes [NUM_S],
  output logic                             wb_ack,
  output logic [NUM_S*sram_lane_width-1:0] wb_dat_r
);

  logic [NUM_S-1:0]                      lane_ack;
  logic [NUM_S-1:0][sram_lane_width-1:0] lane_rdata;
  logic [NUM_S-1:0]                      done;  // lanes finished with the current access

  // interface arrays only take constant indices, so flatten them first
  for (genvar i = 0; i < NUM_S; i++) begin : gen_lane
    assign lane_ack[i]   = lanes[i].ack;
    assign lane_rdata[i] = lanes[i].rdata;
  end

  // high for a single cycle since done is cleared right behind it
  assign wb_ack = &done;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done <= '0;
    end else if (wb_ack) begin
      done <= '0;
    end else begin
      done <= done | lane_ack;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_S; i++) begin
      if (lane_ack[i]) begin
        wb_dat_r[i*sram_lane_width +: sram_lane_width] <= lane_rdata[i];
      end
    end
  end

endmodule

// File: rtl/mem_test_striped.sv
module mem_test_striped import sram_pkg::*; #(
  parameter int NUM_S      = 4,
  parameter int NUM_BURSTS = 16,
  parameter int NUM_BEATS  = 8
) (
  input  logic                         clk,
  input  logic                         rst_n,
  output logic                         test_done,
  output logic                         test_pass,
  output sram_addr_t [NUM_S-1:0]       sram_addr,
  output lane_data_t [NUM_S-1:0]       sram_dout,
  output logic       [NUM_S-1:0]       sram_doe,
  input  lane_data_t [NUM_S-1:0]       sram_din,
  output logic       [NUM_S-1:0]       sram_we_n,
  output logic       [NUM_S-1:0]       sram_oe_n,
  output logic       [NUM_S-1:0]       sram_ce_n
);

  localparam int word_width = NUM_S * sram_lane_width;

  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  sram_addr_t            wb_adr;
  logic [word_width-1:0] wb_dat_w;
  logic                  wb_ack;
  logic [word_width-1:0] wb_dat_r;

  sram_lane_if lane_bus [NUM_S] ();

  mem_test_seq #(
    .NUM_S      (NUM_S),
    .NUM_BURSTS (NUM_BURSTS),
    .NUM_BEATS  (NUM_BEATS)
  ) mem_test_seq_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_ack    (wb_ack),
    .wb_dat_r  (wb_dat_r),
    .test_done (test_done),
    .test_pass (test_pass)
  );

  stripe_split #(
    .NUM_S (NUM_S)
  ) stripe_split_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .lanes    (lane_bus)
  );

  // one controller per chip, all of them step through the same cycle together
  for (genvar i = 0; i < NUM_S; i++) begin : gen_lane
    sram_lane sram_lane_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .bus       (lane_bus[i]),
      .sram_addr (sram_addr[i]),
      .sram_dout (sram_dout[i]),
      .sram_doe  (sram_doe[i]),
      .sram_din  (sram_din[i]),
      .sram_we_n (sram_we_n[i]),
      .sram_oe_n (sram_oe_n[i]),
      .sram_ce_n (sram_ce_n[i])
    );
  end

  stripe_join #(
    .NUM_S (NUM_S)
  ) stripe_join_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .lanes    (lane_bus),
    .wb_ack   (wb_ack),
    .wb_dat_r (wb_dat_r)
  );

endmodule

// File: testbench/sram_model.sv
module sram_model import sram_pkg::*; (
  input  logic                               ce_n,
  input  logic                               we_n,
  input  logic                               oe_n,
  input  logic                               doe,
  input  sram_addr_t                         addr,
  input  lane_data_t                         wdata,
  output lane_data_t                         rdata,
  input  logic                               flip,       // corrupts one stored bit when it rises
  input  sram_addr_t                         flip_addr,
  input  logic [$clog2(sram_lane_width)-1:0] flip_pos,
  input  logic                               freeze,     // takes a copy of the whole array
  input  sram_addr_t                         peek_addr,
  output lane_data_t                         peek_data
);

  lane_data_t mem    [2**sram_addr_width];
  lane_data_t shadow [2**sram_addr_width];

  task automatic flip_bit(sram_addr_t a, logic [$clog2(sram_lane_width)-1:0] pos);
    mem[a][pos] = ~mem[a][pos];
  endtask

  // the chip latches the data bus on the rising edge of we_n
  always @(posedge we_n or posedge flip) begin
    if (flip) begin
      flip_bit(flip_addr, flip_pos);
    end else if (!ce_n && doe) begin
      mem[addr] = wdata;
    end
  end

  always @(posedge freeze) begin
    shadow = mem;
  end

  assign rdata     = (!oe_n && !ce_n) ? mem[addr] : '0;  // bus floats low when not selected
  assign peek_data = shadow[peek_addr];

endmodule

// File: testbench/mem_test_striped_tb.sv
module mem_test_striped_tb import sram_pkg::*, mem_test_pkg::*; ();

  localparam int NUM_S      = 4;
  localparam int NUM_BURSTS = 16;
  localparam int NUM_BEATS  = 8;
  localparam int word_width = NUM_S * sram_lane_width;
  localparam int num_words  = NUM_BURSTS * NUM_BEATS;
  localparam int pos_width  = $clog2(sram_lane_width);
  localparam int wait_limit = 16 * num_words;  // a pass needs about 12 cycles per word

  logic                   clk;
  logic                   rst_n;
  logic                   test_done;
  logic                   test_pass;
  sram_addr_t [NUM_S-1:0] sram_addr;
  lane_data_t [NUM_S-1:0] sram_dout;
  logic       [NUM_S-1:0] sram_doe;
  lane_data_t [NUM_S-1:0] sram_din;
  logic       [NUM_S-1:0] sram_we_n;
  logic       [NUM_S-1:0] sram_oe_n;
  logic       [NUM_S-1:0] sram_ce_n;
  lane_data_t [NUM_S-1:0] peek_data;
  sram_addr_t             peek_addr;
  logic                   freeze;
  logic                   flip_req;
  int                     flip_lane;
  sram_addr_t             flip_addr;
  logic [pos_width-1:0]   flip_pos;
  integer                 seed;
  logic                   done_prev;
  int                     done_count;
  logic                   pass_dropped;

  mem_test_striped #(
    .NUM_S      (NUM_S),
    .NUM_BURSTS (NUM_BURSTS),
    .NUM_BEATS  (NUM_BEATS)
  ) mem_test_striped_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .test_done (test_done),
    .test_pass (test_pass),
    .sram_addr (sram_addr),
    .sram_dout (sram_dout),
    .sram_doe  (sram_doe),
    .sram_din  (sram_din),
    .sram_we_n (sram_we_n),
    .sram_oe_n (sram_oe_n),
    .sram_ce_n (sram_ce_n)
  );

  for (genvar i = 0; i < NUM_S; i++) begin : gen_model
    sram_model sram_model_i (
      .ce_n      (sram_ce_n[i]),
      .we_n      (sram_we_n[i]),
      .oe_n      (sram_oe_n[i]),
      .doe       (sram_doe[i]),
      .addr      (sram_addr[i]),
      .wdata     (sram_dout[i]),
      .rdata     (sram_din[i]),
      .flip      (flip_req && flip_lane == i),
      .flip_addr (flip_addr),
      .flip_pos  (flip_pos),
      .freeze    (freeze),
      .peek_addr (peek_addr),
      .peek_data (peek_data[i])
    );
  end

  always #20 clk = ~clk;

  // word at address a in pass k, cut down to the bus width
  function automatic logic [word_width-1:0] expected_word(sram_addr_t a, logic [31:0] k);
    logic [31:0] addr_part;
    logic [31:0] pass_part;
    addr_part = 32'(a) * pattern_addr_mul;
    pass_part = k * pattern_pass_mul;
    return word_width'(addr_part + pass_part);
  endfunction

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_lane(string name, lane_data_t got, lane_data_t exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_word(string name, logic [word_width-1:0] got,
                            logic [word_width-1:0] exp);
    for (int i = 0; i < NUM_S; i++) begin
      check_lane($sformatf("%s lane %0d", name, i), got[i*sram_lane_width +: sram_lane_width],
                 exp[i*sram_lane_width +: sram_lane_width]);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic wait_for_done();
    int n;
    n = 0;
    next_cycle();
    while (!test_done && n < wait_limit) begin
      next_cycle();
      n++;
    end
    if (!test_done) begin
      $display("timed out waiting for test_done");
      abort_run();
    end
  endtask

  task automatic wait_for_read();
    int n;
    n = 0;
    while (&sram_oe_n && n < wait_limit) begin
      next_cycle();
      n++;
    end
    if (&sram_oe_n) begin
      $display("timed out waiting for the read sweep to start");
      abort_run();
    end
  endtask

  // pin rules and the done pulse are watched mid cycle, away from the clock edge
  always @(negedge clk) begin
    if (rst_n) begin
      for (int i = 0; i < NUM_S; i++) begin
        if (!sram_we_n[i] || !sram_oe_n[i]) begin
          check_flag($sformatf("sram_ce_n[%0d]", i), sram_ce_n[i], 1'b0);
        end
        check_flag($sformatf("sram_we_n[%0d] & sram_oe_n[%0d]", i, i),
                   sram_we_n[i] | sram_oe_n[i], 1'b1);
        if (i > 0) begin
          check_flag($sformatf("sram_we_n[%0d]", i), sram_we_n[i], sram_we_n[0]);
          check_flag($sformatf("sram_oe_n[%0d]", i), sram_oe_n[i], sram_oe_n[0]);
        end
      end
      if (done_prev) begin
        check_flag("test_done", test_done, 1'b0);
      end
      if (test_done) begin
        done_count++;
        if (done_count <= 3) begin
          check_flag("test_pass", test_pass, 1'b1);
        end
      end
      if (pass_dropped) begin
        check_flag("test_pass", test_pass, 1'b0);  // sticky once it fell
      end
      pass_dropped = pass_dropped || !test_pass;
      done_prev    = test_done;
    end
  end

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    peek_addr    = '0;
    freeze       = 1'b0;
    flip_req     = 1'b0;
    flip_lane    = 0;
    flip_addr    = '0;
    flip_pos     = '0;
    done_prev    = 1'b0;
    done_count   = 0;
    pass_dropped = 1'b0;
    seed         = 32'h165e3524;

    repeat (4) next_cycle();
    check_flag("test_done", test_done, 1'b0);
    check_flag("test_pass", test_pass, 1'b1);
    for (int i = 0; i < NUM_S; i++) begin
      check_flag($sformatf("sram_ce_n[%0d]", i), sram_ce_n[i], 1'b1);
      check_flag($sformatf("sram_we_n[%0d]", i), sram_we_n[i], 1'b1);
      check_flag($sformatf("sram_oe_n[%0d]", i), sram_oe_n[i], 1'b1);
      check_flag($sformatf("sram_doe[%0d]", i), sram_doe[i], 1'b0);
    end
    rst_n = 1'b1;

    // pass 1 starts writing a few cycles after test_done, so the chips are copied first
    wait_for_done();
    freeze = 1'b1;
    #1;
    freeze = 1'b0;
    for (int a = 0; a < num_words; a++) begin
      peek_addr = sram_addr_t'(a);
      #1;
      check_word($sformatf("sram word 0x%h", a), peek_data,
                 expected_word(sram_addr_t'(a), 32'd0));
    end

    repeat (2) wait_for_done();
    wait_for_read();
    flip_lane = $unsigned($random(seed)) % NUM_S;
    flip_addr = sram_addr_t'($unsigned($random(seed)) % num_words);
    flip_pos  = pos_width'($unsigned($random(seed)) % sram_lane_width);
    flip_req  = 1'b1;
    #1;
    flip_req  = 1'b0;

    wait_for_done();
    check_flag("test_pass", test_pass, 1'b0);
    wait_for_done();
    check_flag("test_pass", test_pass, 1'b0);

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: vlog.f
rtl/sram_pkg.sv
rtl/mem_test_pkg.sv
rtl/sram_lane_if.sv
rtl/mem_test_seq.sv
rtl/stripe_split.sv
rtl/sram_lane.sv
rtl/stripe_join.sv
rtl/mem_test_striped.sv
testbench/sram_model.sv
testbench/mem_test_striped_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := mem_test_striped_tb
FILELIST  := vlog.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir
